// File: hdl/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// buffer geometry
`define ROB_SIZE 8
`define ROB_ADDR_WIDTH 3

// architectural register index
`define REG_ADDR_WIDTH 5

// exception code carried to commit
`define EXC_TYPE_WIDTH 4

// result and pc
`define DATA_WIDTH 32
`define ADDR_WIDTH 32

`endif

// File: hdl/rob_pkg.sv
`default_nettype none

`include "rob_params.svh"

package rob_pkg;

  // slot number inside the buffer
  typedef logic [`ROB_ADDR_WIDTH-1:0] rob_index_t;

  // slot number plus a wrap bit on top
  // equal pointers mean empty, same index with different wrap means full
  typedef logic [`ROB_ADDR_WIDTH:0] rob_ptr_t;

  // one buffer line
  typedef struct packed {
    logic                       done;
    logic                       reg_write_en;
    logic [`REG_ADDR_WIDTH-1:0] reg_write_addr;
    logic [`EXC_TYPE_WIDTH-1:0] exception_type;
    logic [`DATA_WIDTH-1:0]     result;
    logic [`ADDR_WIDTH-1:0]     pc;
  } rob_entry_t;

endpackage

`default_nettype wire

// File: hdl/rob_pointers.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_pointers (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      read_en,
  input  wire                      write_en,
  input  wire                      commit_en,
  input  wire                      erase_en,
  input  wire rob_pkg::rob_index_t erase_from_addr,
  output rob_pkg::rob_index_t      head_index,
  output rob_pkg::rob_index_t      read_index,
  output rob_pkg::rob_index_t      tail_index,
  output rob_pkg::rob_index_t      head_index_next,
  output rob_pkg::rob_index_t      rob_write_addr,
  output logic                     buffer_empty_next,
  output logic                     can_read,
  output logic                     can_write
);

  rob_pkg::rob_ptr_t head_ptr;
  rob_pkg::rob_ptr_t read_ptr;
  rob_pkg::rob_ptr_t tail_ptr;
  rob_pkg::rob_ptr_t head_ptr_next;
  rob_pkg::rob_ptr_t read_ptr_next;
  rob_pkg::rob_ptr_t tail_ptr_next;
  logic              erase_wrap;
  logic              full_next;

  assign head_ptr_next = commit_en ? head_ptr + 1'b1 : head_ptr;
  assign read_ptr_next = read_en ? read_ptr + 1'b1 : read_ptr;

  // rolled-back tail sits at or after the head
  assign erase_wrap = (erase_from_addr >= head_ptr_next[`ROB_ADDR_WIDTH-1:0]) ?
                      head_ptr_next[`ROB_ADDR_WIDTH] : ~head_ptr_next[`ROB_ADDR_WIDTH];

  // erase wins over a write in the same cycle
  assign tail_ptr_next = erase_en ? {erase_wrap, erase_from_addr} :
                         write_en ? tail_ptr + 1'b1 : tail_ptr;

  assign head_index      = head_ptr[`ROB_ADDR_WIDTH-1:0];
  assign read_index      = read_ptr[`ROB_ADDR_WIDTH-1:0];
  assign tail_index      = tail_ptr[`ROB_ADDR_WIDTH-1:0];
  assign head_index_next = head_ptr_next[`ROB_ADDR_WIDTH-1:0];
  assign rob_write_addr  = tail_ptr_next[`ROB_ADDR_WIDTH-1:0];

  // status of the buffer after this cycle's strobes
  assign buffer_empty_next = head_ptr_next == tail_ptr_next;
  assign full_next = (head_ptr_next[`ROB_ADDR_WIDTH-1:0] == tail_ptr_next[`ROB_ADDR_WIDTH-1:0]) &&
                     (head_ptr_next[`ROB_ADDR_WIDTH] != tail_ptr_next[`ROB_ADDR_WIDTH]);
  assign can_write = !full_next;
  // issue side has caught up with allocation
  assign can_read  = read_ptr_next != tail_ptr_next;

  always_ff @(posedge clk) begin
    if (!rst) begin
      head_ptr <= '0;
      read_ptr <= '0;
      tail_ptr <= '0;
    end else begin
      head_ptr <= head_ptr_next;
      read_ptr <= read_ptr_next;
      tail_ptr <= tail_ptr_next;
    end
  end

endmodule

`default_nettype wire

// File: hdl/rob_entry_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_entry_array (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      write_en,
  input  wire                      update_en,
  input  wire                      erase_en,
  input  wire rob_pkg::rob_index_t tail_index,
  input  wire rob_pkg::rob_index_t update_addr,
  input  wire rob_pkg::rob_entry_t entry_in,
  output rob_pkg::rob_entry_t      entries [`ROB_SIZE]
);

  logic [`ROB_SIZE-1:0] line_write_en;

  // one line per cycle
  // allocation takes the port, an update only gets it when no write is going in
  always_comb begin
    for (int i = 0; i < `ROB_SIZE; i++) begin
      if (write_en && !erase_en) begin
        line_write_en[i] = tail_index == rob_pkg::rob_index_t'(i);
      end else begin
        line_write_en[i] = update_en && (update_addr == rob_pkg::rob_index_t'(i));
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `ROB_SIZE; i++) begin
      if (!rst) begin
        entries[i] <= '0;
      end else if (line_write_en[i]) begin
        entries[i] <= entry_in;
      end
    end
  end

endmodule

`default_nettype wire

// File: hdl/rob_read_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module rob_read_select (
  input  wire                      rst,
  input  wire                      read_en,
  input  wire                      write_en,
  input  wire                      update_en,
  input  wire                      erase_en,
  input  wire rob_pkg::rob_index_t head_index,
  input  wire rob_pkg::rob_index_t read_index,
  input  wire rob_pkg::rob_index_t tail_index,
  input  wire rob_pkg::rob_index_t head_index_next,
  input  wire rob_pkg::rob_index_t update_addr,
  input  wire                      buffer_empty_next,
  input  wire rob_pkg::rob_entry_t entry_in,
  input  wire rob_pkg::rob_entry_t entries [`ROB_SIZE],
  output rob_pkg::rob_entry_t      entry_out,
  output rob_pkg::rob_index_t      rob_read_addr,
  output logic                     can_commit
);

  rob_pkg::rob_index_t sel_index;
  rob_pkg::rob_entry_t sel_entry;
  logic                sel_fwd;
  logic                commit_fwd;
  logic                commit_done;

  // slot gets entry_in on this clock edge
  function automatic logic slot_written(input rob_pkg::rob_index_t slot);
    return (write_en && !erase_en && slot == tail_index) ||
           (update_en && slot == update_addr);
  endfunction

  // issue port shows the head when nothing is being read
  assign sel_index = read_en ? read_index : head_index;
  assign sel_fwd   = slot_written(sel_index);
  assign sel_entry = sel_fwd ? entry_in : entries[sel_index];

  always_comb begin
    if (!rst) begin
      rob_read_addr = '0;
      entry_out     = '0;
    end else begin
      rob_read_addr = sel_index;
      entry_out     = sel_entry;
    end
  end

  // commit check looks at the head as it stands after this cycle
  assign commit_fwd  = slot_written(head_index_next);
  assign commit_done = commit_fwd ? entry_in.done : entries[head_index_next].done;
  assign can_commit  = !buffer_empty_next && commit_done;

endmodule

`default_nettype wire

// File: hdl/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "rob_params.svh"

module reorder_buffer (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      read_en,
  input  wire                      write_en,
  input  wire                      update_en,
  input  wire                      commit_en,
  input  wire                      erase_en,
  input  wire rob_pkg::rob_index_t update_addr,
  input  wire rob_pkg::rob_index_t erase_from_addr,
  input  wire rob_pkg::rob_entry_t entry_in,
  output logic                     can_read,
  output logic                     can_write,
  output logic                     can_commit,
  output rob_pkg::rob_index_t      rob_write_addr,
  output rob_pkg::rob_index_t      rob_read_addr,
  output rob_pkg::rob_entry_t      entry_out
);

  rob_pkg::rob_index_t head_index;
  rob_pkg::rob_index_t read_index;
  rob_pkg::rob_index_t tail_index;
  rob_pkg::rob_index_t head_index_next;
  logic                buffer_empty_next;
  rob_pkg::rob_entry_t entries [`ROB_SIZE];

  rob_pointers u_pointers (
    .clk               (clk),
    .rst               (rst),
    .read_en           (read_en),
    .write_en          (write_en),
    .commit_en         (commit_en),
    .erase_en          (erase_en),
    .erase_from_addr   (erase_from_addr),
    .head_index        (head_index),
    .read_index        (read_index),
    .tail_index        (tail_index),
    .head_index_next   (head_index_next),
    .rob_write_addr    (rob_write_addr),
    .buffer_empty_next (buffer_empty_next),
    .can_read          (can_read),
    .can_write         (can_write)
  );

  // storage, written at the current tail or the update slot
  rob_entry_array u_entry_array (
    .clk         (clk),
    .rst         (rst),
    .write_en    (write_en),
    .update_en   (update_en),
    .erase_en    (erase_en),
    .tail_index  (tail_index),
    .update_addr (update_addr),
    .entry_in    (entry_in),
    .entries     (entries)
  );

  rob_read_select u_read_select (
    .rst               (rst),
    .read_en           (read_en),
    .write_en          (write_en),
    .update_en         (update_en),
    .erase_en          (erase_en),
    .head_index        (head_index),
    .read_index        (read_index),
    .tail_index        (tail_index),
    .head_index_next   (head_index_next),
    .update_addr       (update_addr),
    .buffer_empty_next (buffer_empty_next),
    .entry_in          (entry_in),
    .entries           (entries),
    .entry_out         (entry_out),
    .rob_read_addr     (rob_read_addr),
    .can_commit        (can_commit)
  );

endmodule

`default_nettype wire

// File: dv/rob_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rob_checker (
  input  wire                      clk,
  input  wire                      check_en,
  input  wire [3:0]                test_id,
  input  wire [31:0]               line_no,
  input  wire [31:0]               expected [8],
  input  wire                      can_read,
  input  wire                      can_write,
  input  wire                      can_commit,
  input  wire rob_pkg::rob_index_t rob_write_addr,
  input  wire rob_pkg::rob_index_t rob_read_addr,
  input  wire rob_pkg::rob_entry_t entry_out,
  output int                       check_count = 0,
  output int                       error_count = 0
);

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    return "reset_and_empty";
      4'd2:    return "fill_and_full";
      4'd3:    return "in_order_read";
      4'd4:    return "update_and_commit";
      4'd5:    return "erase";
      4'd6:    return "full_recovery";
      default: return "unknown";
    endcase
  endfunction

  task automatic compare(input string field, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("FAIL %s %s (trace line %0d) expected %0h actual %0h",
               test_name(test_id), field, line_no, exp, act);
    end
  endtask

  // inputs change 1 ns after the rising edge, so the falling edge sees settled values
  always @(negedge clk) begin
    if (check_en) begin
      compare("can_read", expected[0], 32'(can_read));
      compare("can_write", expected[1], 32'(can_write));
      compare("can_commit", expected[2], 32'(can_commit));
      compare("rob_write_addr", expected[3], 32'(rob_write_addr));
      compare("rob_read_addr", expected[4], 32'(rob_read_addr));
      compare("entry_out.done", expected[5], 32'(entry_out.done));
      compare("entry_out.reg_write_addr", expected[6], 32'(entry_out.reg_write_addr));
      compare("entry_out.result", expected[7], entry_out.result);
    end
  end

endmodule

`default_nettype wire

// File: dv/tb_reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module tb_reorder_buffer;

  localparam int MAX_LINES = 64;
  localparam int NUM_COLS  = 21;

  logic                clk;
  logic                rst;
  logic                read_en;
  logic                write_en;
  logic                update_en;
  logic                commit_en;
  logic                erase_en;
  rob_pkg::rob_index_t update_addr;
  rob_pkg::rob_index_t erase_from_addr;
  rob_pkg::rob_entry_t entry_in;
  logic                can_read;
  logic                can_write;
  logic                can_commit;
  rob_pkg::rob_index_t rob_write_addr;
  rob_pkg::rob_index_t rob_read_addr;
  rob_pkg::rob_entry_t entry_out;

  logic [31:0] trace_mem [MAX_LINES][NUM_COLS];
  logic [31:0] expected [8];
  logic [3:0]  test_id;
  logic [31:0] line_no;
  logic        check_en;
  logic        trace_loaded;
  int          line_count;
  int          parse_errors;
  int          check_count;
  int          error_count;

  reorder_buffer DUT (
    .clk             (clk),
    .rst             (rst),
    .read_en         (read_en),
    .write_en        (write_en),
    .update_en       (update_en),
    .commit_en       (commit_en),
    .erase_en        (erase_en),
    .update_addr     (update_addr),
    .erase_from_addr (erase_from_addr),
    .entry_in        (entry_in),
    .can_read        (can_read),
    .can_write       (can_write),
    .can_commit      (can_commit),
    .rob_write_addr  (rob_write_addr),
    .rob_read_addr   (rob_read_addr),
    .entry_out       (entry_out)
  );

  rob_checker u_checker (
    .clk            (clk),
    .check_en       (check_en),
    .test_id        (test_id),
    .line_no        (line_no),
    .expected       (expected),
    .can_read       (can_read),
    .can_write      (can_write),
    .can_commit     (can_commit),
    .rob_write_addr (rob_write_addr),
    .rob_read_addr  (rob_read_addr),
    .entry_out      (entry_out),
    .check_count    (check_count),
    .error_count    (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic load_trace();
    int          fd;
    int          n;
    string       line;
    logic [31:0] v [NUM_COLS];
    fd = $fopen("dv/rob_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file dv/rob_trace.txt");
      parse_errors++;
      return;
    end
    while (!$feof(fd) && line_count < MAX_LINES) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                  v[7], v[8], v[9], v[10], v[11], v[12], v[13],
                  v[14], v[15], v[16], v[17], v[18], v[19], v[20]);
      if (n != NUM_COLS) begin
        $display("a trace line could not be parsed: %s", line);
        parse_errors++;
      end else begin
        for (int c = 0; c < NUM_COLS; c++) begin
          trace_mem[line_count][c] = v[c];
        end
        line_count++;
      end
    end
    $fclose(fd);
  endtask

  // column 0 is the test id
  // columns 1 to 12 drive the DUT, 13 to 20 hold the expected outputs
  task automatic drive_line(input int i);
    rst                     = trace_mem[i][1][0];
    read_en                 = trace_mem[i][2][0];
    write_en                = trace_mem[i][3][0];
    update_en               = trace_mem[i][4][0];
    commit_en               = trace_mem[i][5][0];
    erase_en                = trace_mem[i][6][0];
    update_addr             = trace_mem[i][7][2:0];
    erase_from_addr         = trace_mem[i][8][2:0];
    entry_in.done           = trace_mem[i][9][0];
    entry_in.reg_write_en   = trace_mem[i][10][0];
    entry_in.reg_write_addr = trace_mem[i][11][4:0];
    entry_in.result         = trace_mem[i][12];
    entry_in.exception_type = 4'($urandom);
    entry_in.pc             = $urandom;
    test_id                 = trace_mem[i][0][3:0];
    line_no                 = 32'(i + 1);
    for (int c = 0; c < 8; c++) begin
      expected[c] = trace_mem[i][13 + c];
    end
    check_en = 1'b1;
  endtask

  initial begin
    void'($urandom(22));
    rst          = 1'b0;
    read_en      = 1'b0;
    write_en     = 1'b0;
    update_en    = 1'b0;
    commit_en    = 1'b0;
    erase_en     = 1'b0;
    update_addr  = '0;
    erase_from_addr = '0;
    entry_in     = '0;
    test_id      = '0;
    line_no      = '0;
    check_en     = 1'b0;
    trace_loaded = 1'b0;
    line_count   = 0;
    parse_errors = 0;
    for (int c = 0; c < 8; c++) begin
      expected[c] = '0;
    end
    load_trace();
    trace_loaded = 1'b1;
    for (int i = 0; i < line_count; i++) begin
      @(posedge clk);
      #1;
      drive_line(i);
    end
    @(posedge clk);
    #1;
    check_en = 1'b0;
    @(negedge clk);
    $display("checks: %0d  errors: %0d  trace errors: %0d",
             check_count, error_count, parse_errors);
    if (error_count == 0 && parse_errors == 0 && line_count > 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // limit grows with the trace length
  initial begin
    wait (trace_loaded);
    #((line_count + 20) * 10);
    $display("watchdog: the run did not finish within its time limit");
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: dv/rob_trace.txt
# test rst rd wr up cm er upd_addr erase_addr done reg_we reg_addr result (hex)
# then expected: can_read can_write can_commit wr_addr rd_addr out_done out_reg out_result
1 0 0 0 0 0 0 0 0 0 0 0 0   0 1 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0   0 1 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0 0   0 1 0 0 0 0 0 0
1 1 0 1 0 0 0 0 0 0 1 1 a1  1 1 0 1 0 0 1 a1
2 1 0 1 0 0 0 0 0 0 1 2 a2  1 1 0 2 0 0 1 a1
2 1 0 1 0 0 0 0 0 0 1 3 a3  1 1 0 3 0 0 1 a1
2 1 0 1 0 0 0 0 0 0 1 4 a4  1 1 0 4 0 0 1 a1
2 1 0 1 0 0 0 0 0 0 1 5 a5  1 1 0 5 0 0 1 a1
2 1 0 1 0 0 0 0 0 0 1 6 a6  1 1 0 6 0 0 1 a1
2 1 0 1 0 0 0 0 0 0 1 7 a7  1 1 0 7 0 0 1 a1
2 1 0 1 0 0 0 0 0 0 1 8 a8  1 0 0 0 0 0 1 a1
3 1 1 0 0 0 0 0 0 0 0 0 0   1 0 0 0 0 0 1 a1
3 1 1 0 0 0 0 0 0 0 0 0 0   1 0 0 0 1 0 2 a2
3 1 1 0 0 0 0 0 0 0 0 0 0   1 0 0 0 2 0 3 a3
3 1 1 0 1 0 0 3 0 0 1 4 e4  1 0 0 0 3 0 4 e4
3 1 1 0 0 0 0 0 0 0 0 0 0   1 0 0 0 4 0 5 a5
3 1 1 0 0 0 0 0 0 0 0 0 0   1 0 0 0 5 0 6 a6
3 1 1 0 0 0 0 0 0 0 0 0 0   1 0 0 0 6 0 7 a7
3 1 1 0 0 0 0 0 0 0 0 0 0   0 0 0 0 7 0 8 a8
4 1 0 0 0 0 0 0 0 0 0 0 0   0 0 0 0 0 0 1 a1
4 1 0 0 1 0 0 0 0 1 1 1 b1  0 0 1 0 0 1 1 b1
6 1 0 0 0 1 0 0 0 0 0 0 0   0 1 0 0 0 1 1 b1
4 1 0 0 1 0 0 1 0 1 1 2 b2  0 1 1 0 1 1 2 b2
4 1 0 0 1 1 0 2 0 1 1 3 b3  0 1 1 0 1 1 2 b2
4 1 0 0 0 1 0 0 0 0 0 0 0   0 1 0 0 2 1 3 b3
6 1 0 1 0 0 0 0 0 0 1 9 c0  1 1 0 1 3 0 4 e4
5 1 0 1 0 0 0 0 0 0 1 a c1  1 1 0 2 3 0 4 e4
5 1 0 1 0 0 1 0 1 1 1 1f ff 1 1 0 1 3 0 4 e4
5 1 0 1 0 0 0 0 0 0 1 b c2  1 1 0 2 3 0 4 e4
5 1 0 0 1 0 0 3 0 1 1 4 d3  1 1 1 2 3 1 4 d3
5 1 0 0 1 1 0 4 0 1 1 5 d4  1 1 1 2 3 1 4 d3
5 1 0 0 1 1 0 5 0 1 1 6 d5  1 1 1 2 4 1 5 d4
5 1 0 0 1 1 0 6 0 1 1 7 d6  1 1 1 2 5 1 6 d5
5 1 0 0 1 1 0 7 0 1 1 8 d7  1 1 1 2 6 1 7 d6
5 1 0 0 1 1 0 0 0 1 1 9 d8  1 1 1 2 7 1 8 d7
5 1 0 0 0 1 0 0 0 0 0 0 0   1 1 0 2 0 1 9 d8

// File: filelist.f
+incdir+hdl
hdl/rob_pkg.sv
hdl/rob_pointers.sv
hdl/rob_entry_array.sv
hdl/rob_read_select.sv
hdl/reorder_buffer.sv
dv/rob_checker.sv
dv/tb_reorder_buffer.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_reorder_buffer
FILELIST = filelist.f
PASS_MSG = *** TEST PASSED ***
SIM_BIN  = obj_dir/V$(TOP)

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)
	./$(SIM_BIN) | tee /dev/stderr | grep -qF '$(PASS_MSG)'

clean:
	rm -rf obj_dir
